//--- project.f
+incdir+verilog
verilog/simd_alu_pkg.sv
verilog/simd_op_decoder.sv
verilog/simd_adder.sv
verilog/simd_compare.sv
verilog/simd_shifter.sv
verilog/simd_bit_count.sv
verilog/simd_permute.sv
verilog/simd_alu.sv
tests/simd_alu_tb.sv

//--- tests/simd_alu_tb.sv
/*
 * Self-checking testbench for the packed-SIMD ALU. Issues every opcode
 * group with LCG operands, predicts results with a lane-wise model and
 * checks the registered outputs one cycle later.
 */
`include "simd_alu_params.svh"

`default_nettype none

module simd_alu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import simd_alu_pkg::*;

  logic                  clk_i;
  logic                  rst_n_i;
  logic                  valid_i;
  simd_op_e              op_i;
  simd_operands_t        operands_i;
  logic                  valid_o;
  logic [`SIMD_XLEN-1:0] result_o;
  logic                  ov_o;

  logic [31:0]           lcg_state;
  logic [32:0]           exp_q[$];     // {ov, result}
  string                 name_q[$];
  logic [32:0]           got_exp;
  string                 got_name;
  logic                  strobe_q;
  logic [31:0]           held_result;
  logic                  held_ov;
  string                 cur_name;
  int                    errors;
  int                    checks;
  int                    tests;
  int                    err_start;
  int                    chk_start;

  simd_alu simd_alu_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .valid_i    (valid_i),
    .op_i       (op_i),
    .operands_i (operands_i),
    .valid_o    (valid_o),
    .result_o   (result_o),
    .ov_o       (ov_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Error reporting and stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic void value_mismatch(input string name, input logic [31:0] exp_v,
                                         input logic [31:0] act_v);
    $display("FAIL %s: expected %h, actual %h", name, exp_v, act_v);
    errors++;
  endfunction

  function automatic void report_error(input string msg);
    $display("ERROR: %s", msg);
    errors++;
  endfunction

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Mix of random words and lane edge values
  function automatic logic [31:0] pick_operand();
    logic [31:0] r;
    logic [31:0] k;
    r = lcg_next();
    k = lcg_next();
    case (k[31:28])
      4'd0:    return 32'h0000_0000;
      4'd1:    return 32'hffff_ffff;
      4'd2:    return 32'h7f7f_7f7f;
      4'd3:    return 32'h8080_8080;
      4'd4:    return 32'h7fff_8000;
      4'd5:    return r >> r[4:0];
      4'd6:    return r & 32'h0f07_0301;
      default: return r;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic int lane_bits(input simd_op_e op);
    if (op == CLRS32) begin
      return 32;
    end
    if (op inside {ADD16, SUB16, RADD16, URADD16, KADD16, UKADD16, RSUB16, URSUB16,
                   KSUB16, UKSUB16, CRAS16, CRSA16, STAS16, STSA16, CMPEQ16, SCMPLT16,
                   SCMPLE16, UCMPLT16, UCMPLE16, SMIN16, SMAX16, UMIN16, UMAX16,
                   SRA16, SRL16, SLL16, CLZ16, CLRS16}) begin
      return 16;
    end
    return 8;
  endfunction

  function automatic longint lane_val(input logic [31:0] x, input int i, input int w,
                                      input bit sgn);
    longint v;
    v = longint'(x >> (i * w)) & ((longint'(1) << w) - 1);
    if (sgn && v[w-1]) begin
      v = v - (longint'(1) << w);
    end
    return v;
  endfunction

  function automatic logic [31:0] model_permute(input simd_op_e op, input logic [31:0] a,
                                                input logic [31:0] b,
                                                input logic [31:0] rd);
    int hi;
    int lo;
    bit sx;
    logic [7:0] hb;
    logic [7:0] lb;
    logic [31:0] res;
    case (op)
      PKBB16: return {a[15:0], b[15:0]};
      PKBT16: return {a[15:0], b[31:16]};
      PKTB16: return {a[31:16], b[15:0]};
      PKTT16: return {a[31:16], b[31:16]};
      INSB0, INSB1, INSB2, INSB3: begin
        res = rd;
        res[8 * (int'(op) - int'(INSB0)) +: 8] = a[7:0];
        return res;
      end
      default: ;
    endcase
    // Unpack digits name the source bytes of the upper and lower halfword
    case (op)
      SUNPKD820, ZUNPKD820: begin hi = 2; lo = 0; end
      SUNPKD830, ZUNPKD830: begin hi = 3; lo = 0; end
      SUNPKD831, ZUNPKD831: begin hi = 3; lo = 1; end
      SUNPKD832, ZUNPKD832: begin hi = 3; lo = 2; end
      default:              begin hi = 1; lo = 0; end
    endcase
    sx = op inside {SUNPKD810, SUNPKD820, SUNPKD830, SUNPKD831, SUNPKD832};
    hb = a[8*hi +: 8];
    lb = a[8*lo +: 8];
    return {{8{sx & hb[7]}}, hb, {8{sx & lb[7]}}, lb};
  endfunction

  function automatic logic [32:0] model(input simd_op_e op, input logic [31:0] a,
                                        input logic [31:0] b, input logic [31:0] rd);
    int w;
    int nl;
    int amt;
    int n;
    bit sgn;
    bit sub;
    bit ov;
    longint x;
    longint y;
    longint r;
    longint m;
    longint lim_hi;
    longint lim_lo;
    logic [31:0] res;
    if (op inside {[SUNPKD810:INSB3]}) begin
      return {1'b0, model_permute(op, a, b, rd)};
    end
    w   = lane_bits(op);
    nl  = 32 / w;
    m   = (longint'(1) << w) - 1;
    amt = (w == 16) ? int'(b[3:0]) : int'(b[2:0]);
    sgn = op inside {RADD8, RADD16, KADD8, KADD16, RSUB8, RSUB16, KSUB8, KSUB16,
                     SCMPLT8, SCMPLT16, SCMPLE8, SCMPLE16, SMIN8, SMIN16,
                     SMAX8, SMAX16, SRA8, SRA16};
    lim_hi = sgn ? (m >> 1) : m;
    lim_lo = sgn ? -(m >> 1) - 1 : 0;
    res = '0;
    ov  = 1'b0;
    for (int i = 0; i < nl; i++) begin
      x = lane_val(a, i, w, sgn);
      // Cross forms take the opposite halfword of B
      y = lane_val(b, (op inside {CRAS16, CRSA16}) ? nl - 1 - i : i, w, sgn);
      if (op inside {[ADD8:STSA16]}) begin
        sub = (op inside {SUB8, SUB16, RSUB8, RSUB16, URSUB8, URSUB16, KSUB8, KSUB16,
                          UKSUB8, UKSUB16})
           || ((i == 0) ? (op inside {CRAS16, STAS16}) : (op inside {CRSA16, STSA16}));
        r = sub ? x - y : x + y;
        if (op inside {RADD8, RADD16, URADD8, URADD16, RSUB8, RSUB16, URSUB8, URSUB16}) begin
          r = r >>> 1;
        end
        if (op inside {KADD8, KADD16, UKADD8, UKADD16, KSUB8, KSUB16, UKSUB8, UKSUB16}) begin
          if (r > lim_hi) begin
            r  = lim_hi;
            ov = 1'b1;
          end
          if (r < lim_lo) begin
            r  = lim_lo;
            ov = 1'b1;
          end
        end
      end else if (op inside {[CMPEQ8:UMAX16]}) begin
        case (op)
          CMPEQ8, CMPEQ16:                      r = (x == y) ? m : 0;
          SCMPLT8, SCMPLT16, UCMPLT8, UCMPLT16: r = (x < y) ? m : 0;
          SCMPLE8, SCMPLE16, UCMPLE8, UCMPLE16: r = (x <= y) ? m : 0;
          SMIN8, SMIN16, UMIN8, UMIN16:         r = (x < y) ? x : y;
          default:                              r = (x > y) ? x : y;
        endcase
      end else if (op inside {[SRA8:SLL16]}) begin
        case (op)
          SLL8, SLL16: r = x << amt;
          SRL8, SRL16: r = x >> amt;
          default:     r = x >>> amt;
        endcase
      end else begin
        // CLZ counts from the MSB, CLRS from the bit below the sign
        n = 0;
        if (op inside {CLZ8, CLZ16}) begin
          for (int j = w - 1; j >= 0; j--) begin
            if (x[j] != 1'b0) break;
            n++;
          end
        end else begin
          for (int j = w - 2; j >= 0; j--) begin
            if (x[j] != x[w-1]) break;
            n++;
          end
        end
        r = n;
      end
      res = res | (32'(r & m) << (i * w));
    end
    return {ov, res};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Drivers
  //////////////////////////////////////////////////////////////////////

  task automatic issue(input simd_op_e op, input logic [31:0] a, input logic [31:0] b,
                       input logic [31:0] rd);
    @(posedge clk_i);
    #1;
    valid_i       = 1'b1;
    op_i          = op;
    operands_i.a  = a;
    operands_i.b  = b;
    operands_i.rd = rd;
    exp_q.push_back(model(op, a, b, rd));
    name_q.push_back(cur_name);
  endtask

  // Operands keep moving while no strobe is given
  task automatic idle_cycle();
    @(posedge clk_i);
    #1;
    valid_i      = 1'b0;
    operands_i.a = lcg_next();
    operands_i.b = lcg_next();
  endtask

  task automatic run_range(input simd_op_e first, input simd_op_e last, input int reps);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] k;
    for (int op = int'(first); op <= int'(last); op++) begin
      for (int n = 0; n < reps; n++) begin
        a = pick_operand();
        k = lcg_next();
        b = (k[31:30] == 2'd0) ? a : pick_operand();
        issue(simd_op_e'(op), a, b, lcg_next());
        if (k[29:27] == 3'd0) begin
          idle_cycle();
        end
      end
    end
  endtask

  task automatic start_test(input string name);
    cur_name  = name;
    err_start = errors;
    chk_start = checks;
  endtask

  task automatic finish_test();
    int t;
    idle_cycle();
    t = 0;
    while (exp_q.size() != 0 && t < 10) begin
      @(posedge clk_i);
      t++;
    end
    if (exp_q.size() != 0) begin
      report_error({cur_name, ": timed out waiting for valid_o"});
      exp_q.delete();
      name_q.delete();
    end
    tests++;
    $display("test %-14s %0d checks, %0d errors", cur_name, checks - chk_start,
             errors - err_start);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Output checks
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      strobe_q <= 1'b0;
    end else begin
      strobe_q <= valid_i;
    end
  end

  // Outputs are sampled mid-cycle
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      assert (valid_o === strobe_q)
        else report_error("valid_o did not follow valid_i by exactly one cycle");
      if (valid_o === 1'b1) begin
        if (exp_q.size() == 0) begin
          report_error("valid_o high with no operation pending");
        end else begin
          got_exp  = exp_q.pop_front();
          got_name = name_q.pop_front();
          checks++;
          assert (result_o === got_exp[31:0])
            else value_mismatch(got_name, got_exp[31:0], result_o);
          assert (ov_o === got_exp[32])
            else value_mismatch({got_name, " ov"}, {31'b0, got_exp[32]}, {31'b0, ov_o});
          held_result = result_o;
          held_ov     = ov_o;
        end
      end else begin
        assert (result_o === held_result && ov_o === held_ov)
          else report_error("result_o or ov_o changed while valid_o was low");
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_n_i     = 1'b0;
    valid_i     = 1'b0;
    op_i        = ADD8;
    operands_i  = '0;
    lcg_state   = 32'hd75dacdc;
    held_result = '0;
    held_ov     = 1'b0;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    start_test("reset_strobe");
    @(negedge clk_i);
    assert (valid_o === 1'b0 && ov_o === 1'b0 && result_o === '0)
      else report_error("outputs not cleared by reset");
    // Back-to-back strobes, then a gap
    issue(ADD8, 32'h0102_0304, 32'h1010_1010, '0);
    issue(SUB16, 32'h0001_0000, 32'h0002_0001, '0);
    issue(KADD8, 32'h7f80_7f01, 32'h0180_7f01, '0);
    idle_cycle();
    idle_cycle();
    issue(ADD16, 32'hffff_0001, 32'h0001_ffff, '0);
    finish_test();

    start_test("wrap_addsub");
    run_range(ADD8, SUB16, 40);
    run_range(CRAS16, STSA16, 40);
    finish_test();

    start_test("halve_sat");
    run_range(RADD8, UKSUB16, 40);
    finish_test();

    start_test("compare_minmax");
    run_range(CMPEQ8, UMAX16, 30);
    finish_test();

    start_test("shift");
    run_range(SRA8, SLL16, 40);
    finish_test();

    start_test("count_permute");
    run_range(CLZ8, INSB3, 20);
    finish_test();

    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/simd_alu.sv
/*
 * Packed-SIMD ALU top. Decodes the opcode, runs all units in parallel
 * and registers the selected result one cycle after valid_i.
 */
`include "simd_alu_params.svh"

`default_nettype none

module simd_alu (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         valid_i,
  input  simd_alu_pkg::simd_op_e       op_i,
  input  simd_alu_pkg::simd_operands_t operands_i,
  output logic                         valid_o,
  output logic [`SIMD_XLEN-1:0]        result_o,
  output logic                         ov_o
);
  import simd_alu_pkg::*;

  simd_ctrl_t                  ctrl;
  logic [`SIMD_XLEN-1:0]       add_res;
  logic [`SIMD_XLEN-1:0]       cmp_res;
  logic [`SIMD_XLEN-1:0]       shift_res;
  logic [`SIMD_XLEN-1:0]       count_res;
  logic [`SIMD_XLEN-1:0]       perm_res;
  logic [`SIMD_XLEN-1:0]       result_d;
  logic [`SIMD_NUM_BYTES-1:0]  add_ov;

  simd_op_decoder decoder_i (
    .op_i   (op_i),
    .ctrl_o (ctrl)
  );

  simd_adder adder_i (
    .ctrl_i     (ctrl),
    .operands_i (operands_i),
    .sum_o      (add_res),
    .ov_o       (add_ov)
  );

  simd_compare compare_i (
    .ctrl_i     (ctrl),
    .operands_i (operands_i),
    .cmp_o      (cmp_res)
  );

  simd_shifter shifter_i (
    .ctrl_i     (ctrl),
    .operands_i (operands_i),
    .shift_o    (shift_res)
  );

  simd_bit_count bit_count_i (
    .ctrl_i     (ctrl),
    .operands_i (operands_i),
    .count_o    (count_res)
  );

  simd_permute permute_i (
    .op_i       (op_i),
    .operands_i (operands_i),
    .perm_o     (perm_res)
  );

  //////////////////////////////////////////////////////////////////////
  // Result select and output stage
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (ctrl.result_sel)
      RES_CMP:   result_d = cmp_res;
      RES_SHIFT: result_d = shift_res;
      RES_COUNT: result_d = count_res;
      RES_PERM:  result_d = perm_res;
      default:   result_d = add_res;
    endcase
  end

  // Result and flag hold between strobes
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o  <= 1'b0;
      result_o <= '0;
      ov_o     <= 1'b0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        result_o <= result_d;
        ov_o     <= |add_ov;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/simd_permute.sv
/*
 * Data movement unit: signed and zero byte unpacks, halfword packs
 * of A and B, and insertion of A's low byte into rd.
 */
`include "simd_alu_params.svh"

`default_nettype none

module simd_permute (
  input  simd_alu_pkg::simd_op_e       op_i,
  input  simd_alu_pkg::simd_operands_t operands_i,
  output logic [`SIMD_XLEN-1:0]        perm_o
);
  import simd_alu_pkg::*;

  localparam int XLEN = `SIMD_XLEN;
  localparam int BW   = `SIMD_BYTE_W;
  localparam int HW   = `SIMD_HALF_W;

  logic [3:0]      unpk_sel;    // {upper byte index, lower byte index}
  logic            unpk_sext;
  logic [BW-1:0]   hi_byte;
  logic [BW-1:0]   lo_byte;
  logic [XLEN-1:0] unpk_word;

  // Byte pair named by the opcode digits
  always_comb begin
    unique case (op_i)
      SUNPKD820, ZUNPKD820: unpk_sel = {2'd2, 2'd0};
      SUNPKD830, ZUNPKD830: unpk_sel = {2'd3, 2'd0};
      SUNPKD831, ZUNPKD831: unpk_sel = {2'd3, 2'd1};
      SUNPKD832, ZUNPKD832: unpk_sel = {2'd3, 2'd2};
      default:              unpk_sel = {2'd1, 2'd0};
    endcase
  end

  assign unpk_sext = op_i inside {SUNPKD810, SUNPKD820, SUNPKD830, SUNPKD831, SUNPKD832};
  assign hi_byte   = operands_i.a[BW*unpk_sel[3:2] +: BW];
  assign lo_byte   = operands_i.a[BW*unpk_sel[1:0] +: BW];
  assign unpk_word = {{BW{unpk_sext & hi_byte[BW-1]}}, hi_byte,
                      {BW{unpk_sext & lo_byte[BW-1]}}, lo_byte};

  always_comb begin
    unique case (op_i)
      // Packs, A supplies the upper halfword
      PKBB16: perm_o = {operands_i.a[HW-1:0],    operands_i.b[HW-1:0]};
      PKBT16: perm_o = {operands_i.a[HW-1:0],    operands_i.b[XLEN-1:HW]};
      PKTB16: perm_o = {operands_i.a[XLEN-1:HW], operands_i.b[HW-1:0]};
      PKTT16: perm_o = {operands_i.a[XLEN-1:HW], operands_i.b[XLEN-1:HW]};
      // Insert byte keeps the rest of rd
      INSB0: perm_o = {operands_i.rd[XLEN-1:BW], operands_i.a[BW-1:0]};
      INSB1: perm_o = {operands_i.rd[XLEN-1:2*BW], operands_i.a[BW-1:0],
                       operands_i.rd[BW-1:0]};
      INSB2: perm_o = {operands_i.rd[XLEN-1:3*BW], operands_i.a[BW-1:0],
                       operands_i.rd[2*BW-1:0]};
      INSB3: perm_o = {operands_i.a[BW-1:0], operands_i.rd[3*BW-1:0]};
      default: perm_o = unpk_word;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/simd_bit_count.sv
/*
 * Leading-zero and leading-redundant-sign counter for 8, 16 and
 * 32 bit lanes. A run mask is summed by a layered adder tree.
 */
`include "simd_alu_params.svh"

`default_nettype none

module simd_bit_count (
  input  simd_alu_pkg::simd_ctrl_t     ctrl_i,
  input  simd_alu_pkg::simd_operands_t operands_i,
  output logic [`SIMD_XLEN-1:0]        count_o
);
  import simd_alu_pkg::*;

  localparam int XLEN = `SIMD_XLEN;
  localparam int BW   = `SIMD_BYTE_W;
  localparam int HW   = `SIMD_HALF_W;
  localparam int NB   = `SIMD_NUM_BYTES;

  logic [XLEN-1:0]          run;
  logic [XLEN/2-1:0][1:0]   l1;
  logic [XLEN/4-1:0][2:0]   l2;
  logic [NB-1:0][3:0]       l3;     // byte counts
  logic [NB/2-1:0][4:0]     l4;     // halfword counts
  logic [5:0]               l5;     // word count

  // Leading-run mask, scanned from each lane's MSB down
  always_comb begin
    logic alive;
    logic sign;
    logic lane_top;
    alive = 1'b0;
    sign  = 1'b0;
    for (int i = XLEN - 1; i >= 0; i--) begin
      unique case (ctrl_i.width)
        W32:     lane_top = (i == XLEN - 1);
        W16:     lane_top = (i % HW == HW - 1);
        default: lane_top = (i % BW == BW - 1);
      endcase
      if (lane_top) begin
        alive = 1'b1;
        sign  = operands_i.a[i];
      end
      // Sign count works on the inverted operand of negative lanes
      alive  = alive & ~(operands_i.a[i] ^ (ctrl_i.count_sign & sign));
      // the sign bit itself is not counted
      run[i] = alive & ~(ctrl_i.count_sign & lane_top);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Adder tree
  //////////////////////////////////////////////////////////////////////

  for (genvar g = 0; g < XLEN / 2; g++) begin : gen_l1
    assign l1[g] = {1'b0, run[2*g]} + {1'b0, run[2*g+1]};
  end

  for (genvar g = 0; g < XLEN / 4; g++) begin : gen_l2
    assign l2[g] = {1'b0, l1[2*g]} + {1'b0, l1[2*g+1]};
  end

  for (genvar g = 0; g < NB; g++) begin : gen_l3
    assign l3[g] = {1'b0, l2[2*g]} + {1'b0, l2[2*g+1]};
  end

  for (genvar g = 0; g < NB / 2; g++) begin : gen_l4
    assign l4[g] = {1'b0, l3[2*g]} + {1'b0, l3[2*g+1]};
  end

  assign l5 = {1'b0, l4[0]} + {1'b0, l4[1]};

  // Zero-extend each count into its lane
  always_comb begin
    unique case (ctrl_i.width)
      W32: count_o = {{(XLEN-6){1'b0}}, l5};
      W16: count_o = {{(HW-5){1'b0}}, l4[1], {(HW-5){1'b0}}, l4[0]};
      default: begin
        for (int k = 0; k < NB; k++) begin
          count_o[BW*k +: BW] = {{(BW-4){1'b0}}, l3[k]};
        end
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/simd_shifter.sv
/*
 * Lane shifter for SLL, SRL and SRA in byte or halfword lanes.
 * Left shifts reuse the right shifter on bit-reversed data.
 */
`include "simd_alu_params.svh"

`default_nettype none

module simd_shifter (
  input  simd_alu_pkg::simd_ctrl_t     ctrl_i,
  input  simd_alu_pkg::simd_operands_t operands_i,
  output logic [`SIMD_XLEN-1:0]        shift_o
);
  import simd_alu_pkg::*;

  localparam int XLEN = `SIMD_XLEN;
  localparam int BW   = `SIMD_BYTE_W;
  localparam int HW   = `SIMD_HALF_W;

  logic            half_lanes;
  logic            shl;
  logic [3:0]      amt;
  logic [XLEN-1:0] src;
  logic [XLEN-1:0] shr;

  function automatic logic [XLEN-1:0] bit_rev(input logic [XLEN-1:0] x);
    logic [XLEN-1:0] r;
    for (int i = 0; i < XLEN; i++) begin
      r[i] = x[XLEN-1-i];
    end
    return r;
  endfunction

  assign half_lanes = (ctrl_i.width == W16);
  assign shl        = (ctrl_i.shift_mode == SHL);
  assign amt        = half_lanes ? operands_i.b[3:0] : {1'b0, operands_i.b[2:0]};

  // Word reversal keeps lane boundaries in place
  assign src = shl ? bit_rev(operands_i.a) : operands_i.a;

  always_comb begin
    int lw;
    int off;
    for (int i = 0; i < XLEN; i++) begin
      lw  = half_lanes ? HW : BW;
      off = half_lanes ? (i % HW) : (i % BW);
      if (off + amt < lw) begin
        shr[i] = src[i + amt];
      end else begin
        // sign of the lane for SRA, zero otherwise
        shr[i] = (ctrl_i.shift_mode == SHR_ARITH) & src[i - off + lw - 1];
      end
    end
  end

  assign shift_o = shl ? bit_rev(shr) : shr;

endmodule

`default_nettype wire

//--- verilog/simd_compare.sv
/*
 * Lane comparator. Produces all-ones or zero lanes for eq, lt and le,
 * and selects per lane between A and B for min and max.
 */
`include "simd_alu_params.svh"

`default_nettype none

module simd_compare (
  input  simd_alu_pkg::simd_ctrl_t     ctrl_i,
  input  simd_alu_pkg::simd_operands_t operands_i,
  output logic [`SIMD_XLEN-1:0]        cmp_o
);
  import simd_alu_pkg::*;

  localparam int BW = `SIMD_BYTE_W;
  localparam int NB = `SIMD_NUM_BYTES;

  logic [NB-1:0] eq_b;
  logic [NB-1:0] ult_b;
  logic [NB-1:0] lt_top;    // signedness applies to the top byte only
  logic [NB-1:0] lane_eq;
  logic [NB-1:0] lane_lt;
  logic [NB-1:0] hit;

  // Per-byte relations
  always_comb begin
    for (int k = 0; k < NB; k++) begin
      eq_b[k]   = operands_i.a[BW*k +: BW] == operands_i.b[BW*k +: BW];
      ult_b[k]  = operands_i.a[BW*k +: BW] <  operands_i.b[BW*k +: BW];
      lt_top[k] = ctrl_i.signed_ops ?
                  ($signed(operands_i.a[BW*k +: BW]) < $signed(operands_i.b[BW*k +: BW])) :
                  ult_b[k];
    end
  end

  always_comb begin
    int hi;
    int lo;
    for (int k = 0; k < NB; k++) begin
      // Halfword lanes combine the upper and lower byte
      hi = (ctrl_i.width == W16) ? (k | 1) : k;
      lo = (ctrl_i.width == W16) ? (k & ~1) : k;
      lane_eq[k] = eq_b[hi] & eq_b[lo];
      lane_lt[k] = lt_top[hi] | (eq_b[hi] & ult_b[lo]);

      unique case (ctrl_i.cmp_mode)
        LT, MIN: hit[k] = lane_lt[k];
        LE:      hit[k] = lane_lt[k] | lane_eq[k];
        MAX:     hit[k] = ~(lane_lt[k] | lane_eq[k]);
        default: hit[k] = lane_eq[k];
      endcase

      if (ctrl_i.cmp_mode inside {MIN, MAX}) begin
        cmp_o[BW*k +: BW] = hit[k] ? operands_i.a[BW*k +: BW] : operands_i.b[BW*k +: BW];
      end else begin
        cmp_o[BW*k +: BW] = {BW{hit[k]}};
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/simd_adder.sv
/*
 * Lane adder built from four byte adders. Covers wrap, halving and
 * saturating add/sub in byte and halfword lanes plus the cross pairs.
 */
`include "simd_alu_params.svh"

`default_nettype none

module simd_adder (
  input  simd_alu_pkg::simd_ctrl_t     ctrl_i,
  input  simd_alu_pkg::simd_operands_t operands_i,
  output logic [`SIMD_XLEN-1:0]        sum_o,
  output logic [`SIMD_NUM_BYTES-1:0]   ov_o
);
  import simd_alu_pkg::*;

  localparam int XLEN = `SIMD_XLEN;
  localparam int BW   = `SIMD_BYTE_W;
  localparam int HW   = `SIMD_HALF_W;
  localparam int NB   = `SIMD_NUM_BYTES;

  logic                half_lanes;
  logic                sgn;
  logic [XLEN-1:0]     b_sw;
  logic [NB-1:0]       sub_b;      // subtract flag of each byte
  logic [NB-1:0][BW:0] sum;        // byte adders with carry out
  logic [NB-1:0]       top;        // bit w of the exact lane result
  logic                carry;
  logic [NB-1:0]       is_top;
  logic [NB-1:0]       lane_ov;
  logic [NB-1:0]       lane_max;   // clamp towards the upper limit
  logic [NB-1:0][BW-1:0] halve_b;
  logic [NB-1:0][BW-1:0] sat_b;

  assign half_lanes = (ctrl_i.width == W16);
  assign sgn        = ctrl_i.signed_ops;

  // Crossed forms pair each half of A with the other half of B
  assign b_sw = ctrl_i.crossed ? {operands_i.b[HW-1:0], operands_i.b[XLEN-1:HW]}
                               : operands_i.b;

  //////////////////////////////////////////////////////////////////////
  // Byte adders
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    carry = 1'b0;
    for (int k = 0; k < NB; k++) begin
      sub_b[k] = (k < NB / 2) ? ctrl_i.sub_lo : ctrl_i.sub_hi;
      // Carry only ripples into the upper byte of a halfword
      sum[k] = {1'b0, operands_i.a[BW*k +: BW]}
             + {1'b0, b_sw[BW*k +: BW] ^ {BW{sub_b[k]}}}
             + {{BW{1'b0}}, (half_lanes && (k % 2 == 1)) ? carry : sub_b[k]};
      carry = sum[k][BW];
      // Extension bits of both operands plus carry out
      top[k] = (sgn & operands_i.a[BW*k+BW-1])
             ^ ((sgn & b_sw[BW*k+BW-1]) ^ sub_b[k])
             ^ sum[k][BW];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Result forms
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    int t;
    for (int k = 0; k < NB; k++) begin
      // Byte that carries this lane's most significant bits
      t = (half_lanes && (k % 2 == 0)) ? k + 1 : k;
      is_top[k]   = (t == k);
      lane_ov[k]  = sgn ? (top[t] ^ sum[t][BW-1]) : top[t];
      lane_max[k] = sgn ? ~top[t] : ~sub_b[t];

      // exact >> 1, the low byte takes bit 0 of its upper neighbour
      halve_b[k] = {is_top[k] ? top[k] : sum[t][0], sum[k][BW-1:1]};

      // 7f..ff / 80..00 signed, ff / 00 unsigned
      if (lane_ov[k]) begin
        sat_b[k] = {is_top[k] ? (lane_max[k] ^ sgn) : lane_max[k], {(BW-1){lane_max[k]}}};
      end else begin
        sat_b[k] = sum[k][BW-1:0];
      end

      unique case (ctrl_i.add_mode)
        HALVE:   sum_o[BW*k +: BW] = halve_b[k];
        SAT:     sum_o[BW*k +: BW] = sat_b[k];
        default: sum_o[BW*k +: BW] = sum[k][BW-1:0];
      endcase
      ov_o[k] = (ctrl_i.add_mode == SAT) && lane_ov[k];
    end
  end

endmodule

`default_nettype wire

//--- verilog/simd_op_decoder.sv
/*
 * Opcode decoder. Maps each instruction onto the control fields
 * consumed by the adder, compare, shift and count units.
 */
`default_nettype none

module simd_op_decoder (
  input  simd_alu_pkg::simd_op_e   op_i,
  output simd_alu_pkg::simd_ctrl_t ctrl_o
);
  import simd_alu_pkg::*;

  logic sub_both;

  // Plain, halving and saturating subtracts use both halves
  assign sub_both = op_i inside {SUB8, SUB16, RSUB8, RSUB16, URSUB8, URSUB16,
                                 KSUB8, KSUB16, UKSUB8, UKSUB16};

  always_comb begin
    // All-zero selects W8, WRAP, EQ, SHL and the adder result
    ctrl_o = '0;

    unique case (op_i)
      ADD16, SUB16, RADD16, URADD16, KADD16, UKADD16, RSUB16, URSUB16,
      KSUB16, UKSUB16, CRAS16, CRSA16, STAS16, STSA16, CMPEQ16, SCMPLT16,
      SCMPLE16, UCMPLT16, UCMPLE16, SMIN16, SMAX16, UMIN16, UMAX16,
      SRA16, SRL16, SLL16, CLZ16, CLRS16: ctrl_o.width = W16;
      CLRS32:                             ctrl_o.width = W32;
      default:                            ctrl_o.width = W8;
    endcase

    ctrl_o.signed_ops = op_i inside {RADD8, RADD16, KADD8, KADD16, RSUB8, RSUB16,
                                     KSUB8, KSUB16, SCMPLT8, SCMPLT16, SCMPLE8,
                                     SCMPLE16, SMIN8, SMIN16, SMAX8, SMAX16};

    // AS forms subtract low, SA forms subtract high
    ctrl_o.sub_lo     = sub_both | (op_i inside {CRAS16, STAS16});
    ctrl_o.sub_hi     = sub_both | (op_i inside {CRSA16, STSA16});
    ctrl_o.crossed    = op_i inside {CRAS16, CRSA16};
    ctrl_o.count_sign = op_i inside {CLRS8, CLRS16, CLRS32};

    unique case (op_i)
      RADD8, RADD16, URADD8, URADD16,
      RSUB8, RSUB16, URSUB8, URSUB16: ctrl_o.add_mode = HALVE;
      KADD8, KADD16, UKADD8, UKADD16,
      KSUB8, KSUB16, UKSUB8, UKSUB16: ctrl_o.add_mode = SAT;
      default:                        ctrl_o.add_mode = WRAP;
    endcase

    unique case (op_i)
      SCMPLT8, SCMPLT16, UCMPLT8, UCMPLT16: ctrl_o.cmp_mode = LT;
      SCMPLE8, SCMPLE16, UCMPLE8, UCMPLE16: ctrl_o.cmp_mode = LE;
      SMIN8, SMIN16, UMIN8, UMIN16:         ctrl_o.cmp_mode = MIN;
      SMAX8, SMAX16, UMAX8, UMAX16:         ctrl_o.cmp_mode = MAX;
      default:                              ctrl_o.cmp_mode = EQ;
    endcase

    unique case (op_i)
      SRA8, SRA16: ctrl_o.shift_mode = SHR_ARITH;
      SRL8, SRL16: ctrl_o.shift_mode = SHR_LOG;
      default:     ctrl_o.shift_mode = SHL;
    endcase

    // Result source
    unique case (op_i)
      CMPEQ8, CMPEQ16, SCMPLT8, SCMPLT16, SCMPLE8, SCMPLE16,
      UCMPLT8, UCMPLT16, UCMPLE8, UCMPLE16,
      SMIN8, SMIN16, SMAX8, SMAX16, UMIN8, UMIN16, UMAX8, UMAX16:
        ctrl_o.result_sel = RES_CMP;
      SRA8, SRA16, SRL8, SRL16, SLL8, SLL16:
        ctrl_o.result_sel = RES_SHIFT;
      CLZ8, CLZ16, CLRS8, CLRS16, CLRS32:
        ctrl_o.result_sel = RES_COUNT;
      SUNPKD810, SUNPKD820, SUNPKD830, SUNPKD831, SUNPKD832,
      ZUNPKD810, ZUNPKD820, ZUNPKD830, ZUNPKD831, ZUNPKD832,
      PKBB16, PKBT16, PKTB16, PKTT16, INSB0, INSB1, INSB2, INSB3:
        ctrl_o.result_sel = RES_PERM;
      default:
        ctrl_o.result_sel = RES_ADD;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/simd_alu_pkg.sv
/*
 * Types shared across the SIMD ALU: opcodes, decoded control fields
 * and the operand bundle. Imported by the datapath and the testbench.
 */
`include "simd_alu_params.svh"

`default_nettype none

package simd_alu_pkg;

  // One entry per supported instruction
  typedef enum logic [6:0] {
    ADD8, ADD16, SUB8, SUB16,
    RADD8, RADD16, URADD8, URADD16, KADD8, KADD16, UKADD8, UKADD16,
    RSUB8, RSUB16, URSUB8, URSUB16, KSUB8, KSUB16, UKSUB8, UKSUB16,
    CRAS16, CRSA16, STAS16, STSA16,
    CMPEQ8, CMPEQ16, SCMPLT8, SCMPLT16, SCMPLE8, SCMPLE16,
    UCMPLT8, UCMPLT16, UCMPLE8, UCMPLE16,
    SMIN8, SMIN16, SMAX8, SMAX16, UMIN8, UMIN16, UMAX8, UMAX16,
    SRA8, SRA16, SRL8, SRL16, SLL8, SLL16,
    CLZ8, CLZ16, CLRS8, CLRS16, CLRS32,
    SUNPKD810, SUNPKD820, SUNPKD830, SUNPKD831, SUNPKD832,
    ZUNPKD810, ZUNPKD820, ZUNPKD830, ZUNPKD831, ZUNPKD832,
    PKBB16, PKBT16, PKTB16, PKTT16,
    INSB0, INSB1, INSB2, INSB3
  } simd_op_e;

  typedef enum logic [1:0] {W8, W16, W32} lane_width_e;

  typedef enum logic [1:0] {WRAP, HALVE, SAT} add_mode_e;

  typedef enum logic [2:0] {EQ, LT, LE, MIN, MAX} cmp_mode_e;

  typedef enum logic [1:0] {SHL, SHR_LOG, SHR_ARITH} shift_mode_e;

  typedef enum logic [2:0] {
    RES_ADD, RES_CMP, RES_SHIFT, RES_COUNT, RES_PERM
  } result_sel_e;

  // rd only matters for insert byte
  typedef struct packed {
    logic [`SIMD_XLEN-1:0] a;
    logic [`SIMD_XLEN-1:0] b;
    logic [`SIMD_XLEN-1:0] rd;
  } simd_operands_t;

  typedef struct packed {
    lane_width_e width;
    logic        signed_ops;
    logic        sub_lo;     // lower halfword subtracts
    logic        sub_hi;     // upper halfword subtracts
    logic        crossed;
    add_mode_e   add_mode;
    cmp_mode_e   cmp_mode;
    shift_mode_e shift_mode;
    logic        count_sign;
    result_sel_e result_sel;
  } simd_ctrl_t;

endpackage

`default_nettype wire

//--- verilog/simd_alu_params.svh
/*
 * Operand width and lane geometry of the packed-SIMD ALU.
 * Included by the package, the datapath units and the testbench.
 */
`ifndef SIMD_ALU_PARAMS_SVH
`define SIMD_ALU_PARAMS_SVH

`default_nettype none

// Operand and lane sizes
`define SIMD_XLEN      32
`define SIMD_BYTE_W    8
`define SIMD_HALF_W    16
`define SIMD_NUM_BYTES 4

`default_nettype wire

`endif
